// ==== vlog.f ====
verilog/cpu_pkg.sv
verilog/decoder.sv
verilog/reg_file.sv
verilog/muxs.sv
verilog/alu.sv
verilog/data_mem.sv
verilog/sys_reg.sv
verilog/exec_core.sv
tb/exec_core_chk.sv
tb/exec_core_tb.sv

// ==== tb/exec_core_tb.sv ====
`timescale 1ns/1ps
module exec_core_tb;

	logic clk;
	logic rst;
	logic instr_valid;
	logic [31:0] instr;
	logic [31:0] instr_pc;
	logic wb_valid;
	logic [4:0] wb_addr;
	logic [31:0] wb_data;

	integer seed;
	logic [4:0] exp_addr[$];
	logic [31:0] exp_data[$];

	// shadow state of the model.
	logic [31:0] m_regs [0:31];
	logic [31:0] m_mem [0:255];
	logic [31:0] m_sr [0:3];

	cpu_pkg::opcode_e rr_ops [6] = '{cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_and,
		cpu_pkg::op_or, cpu_pkg::op_xor, cpu_pkg::op_sll};
	cpu_pkg::opcode_e all_ops [21] = '{cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_and,
		cpu_pkg::op_or, cpu_pkg::op_xor, cpu_pkg::op_sll, cpu_pkg::op_addi, cpu_pkg::op_ori,
		cpu_pkg::op_slli, cpu_pkg::op_movi, cpu_pkg::op_sethi, cpu_pkg::op_lwi,
		cpu_pkg::op_swi, cpu_pkg::op_lw, cpu_pkg::op_sw, cpu_pkg::op_lwr, cpu_pkg::op_lnk,
		cpu_pkg::op_mov, cpu_pkg::op_mtsr, cpu_pkg::op_mfsr, cpu_pkg::op_nop};

	exec_core exec_core_i (
		.clk(clk), .rst(rst), .instr_valid(instr_valid), .instr(instr),
		.instr_pc(instr_pc), .wb_valid(wb_valid), .wb_addr(wb_addr), .wb_data(wb_data)
	);

	bind exec_core exec_core_chk exec_core_chk_i (.*);

	always #5 clk = ~clk;

	task automatic stop_run();
		$display("Testbench failed");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_eq(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
			stop_run();
		end
	endtask

	// expected register write of one instruction, updates shadow state.
	function automatic bit ref_model(input logic [31:0] ins, input logic [31:0] pc,
			output logic [4:0] waddr, output logic [31:0] wdata);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] t;
		logic [31:0] s15;
		logic [31:0] ea;
		bit wr;
		a = m_regs[ins[20:16]];
		b = m_regs[ins[15:11]];
		t = m_regs[ins[25:21]];
		s15 = {{17{ins[14]}}, ins[14:0]};
		ea = a + (s15 << 2);
		waddr = ins[25:21];
		wdata = '0;
		wr = 1'b1;
		case (cpu_pkg::opcode_e'(ins[31:26]))
			cpu_pkg::op_add: wdata = a + b;
			cpu_pkg::op_sub: wdata = a - b;
			cpu_pkg::op_and: wdata = a & b;
			cpu_pkg::op_or: wdata = a | b;
			cpu_pkg::op_xor: wdata = a ^ b;
			cpu_pkg::op_sll: wdata = a << b[4:0];
			cpu_pkg::op_addi: wdata = a + s15;
			cpu_pkg::op_ori: wdata = a | {17'b0, ins[14:0]};
			cpu_pkg::op_slli: wdata = a << ins[14:10];
			cpu_pkg::op_movi: wdata = {{12{ins[19]}}, ins[19:0]};
			cpu_pkg::op_sethi: wdata = {ins[19:0], 12'b0};
			cpu_pkg::op_lwi: wdata = m_mem[ea[9:2]];
			cpu_pkg::op_lw: begin
				ea = a + (b << ins[9:8]);
				wdata = m_mem[ea[9:2]];
			end
			cpu_pkg::op_lwr: wdata = m_mem[a[9:2]];
			cpu_pkg::op_swi: begin
				m_mem[ea[9:2]] = t;
				wr = 1'b0;
			end
			cpu_pkg::op_sw: begin
				ea = a + (b << ins[9:8]);
				m_mem[ea[9:2]] = t;
				wr = 1'b0;
			end
			cpu_pkg::op_lnk: begin
				waddr = 5'd30;
				wdata = pc + 32'd4;
			end
			cpu_pkg::op_mov: wdata = t;
			cpu_pkg::op_mtsr: begin
				m_sr[ins[1:0]] = t;
				wr = 1'b0;
			end
			cpu_pkg::op_mfsr: wdata = m_sr[ins[1:0]];
			default: wr = 1'b0;
		endcase
		if (wr) begin
			m_regs[waddr] = wdata;
		end
		return wr;
	endfunction

	function automatic logic [31:0] enc_r(input cpu_pkg::opcode_e op, input logic [4:0] rt,
			input logic [4:0] ra, input logic [4:0] rb, input logic [1:0] sv);
		return {op, rt, ra, rb, 1'b0, sv, 8'h00};
	endfunction

	function automatic logic [31:0] enc_i(input cpu_pkg::opcode_e op, input logic [4:0] rt,
			input logic [4:0] ra, input logic [14:0] imm);
		return {op, rt, ra, 1'b0, imm};
	endfunction

	function automatic logic [31:0] enc_u(input cpu_pkg::opcode_e op, input logic [4:0] rt,
			input logic [19:0] imm);
		return {op, rt, 1'b0, imm};
	endfunction

	function automatic logic [31:0] rand_word();
		return $random(seed);
	endfunction

	// r1 to r29, keeps clear of the link register.
	function automatic logic [4:0] rand_reg();
		logic [31:0] w;
		w = $random(seed);
		return (w[4:0] % 5'd29) + 5'd1;
	endfunction

	// one instruction, then one idle cycle.
	task automatic issue(input logic [31:0] ins);
		logic [31:0] pc;
		logic [4:0] a;
		logic [31:0] d;
		pc = $random(seed);
		pc[1:0] = 2'b00;
		@(negedge clk);
		instr_valid = 1'b1;
		instr = ins;
		instr_pc = pc;
		if (ref_model(ins, pc, a, d)) begin
			exp_addr.push_back(a);
			exp_data.push_back(d);
		end
		@(negedge clk);
		instr_valid = 1'b0;
	endtask

	task automatic set_reg(input logic [4:0] r, input logic [31:0] v);
		issue(enc_u(cpu_pkg::op_sethi, r, v[31:12]));
		issue(enc_i(cpu_pkg::op_ori, r, r, {3'b000, v[11:0]}));
	endtask

	initial begin : compare_trace
		int idle;
		idle = 0;
		forever begin
			@(negedge clk);
			if (wb_valid === 1'b1) begin
				idle = 0;
				if (exp_addr.size() == 0) begin
					$display("register write on the trace port where none was expected");
					stop_run();
				end else begin
					check_eq("wb_addr", {27'b0, wb_addr}, {27'b0, exp_addr.pop_front()});
					check_eq("wb_data", wb_data, exp_data.pop_front());
				end
			end else if (exp_addr.size() != 0) begin
				idle++;
				if (idle > 8) begin
					$display("timeout waiting for an expected register write on the trace");
					stop_run();
				end
			end else begin
				idle = 0;
			end
		end
	end

	initial begin : stimulus
		logic [31:0] w;
		logic [31:0] u;
		int n;
		seed = 32'h93db;
		clk = 1'b0;
		rst = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		instr_pc = '0;
		for (int i = 0; i < 32; i++) begin
			m_regs[i] = '0;
		end
		for (int i = 0; i < 4; i++) begin
			m_sr[i] = '0;
		end
		repeat (5) @(negedge clk);
		rst = 1'b0;

		// registers read zero after reset.
		repeat (4) issue(enc_r(cpu_pkg::op_mov, rand_reg(), 5'd0, 5'd0, 2'd0));
		issue(enc_r(cpu_pkg::op_nop, 5'd1, 5'd2, 5'd3, 2'd0));
		issue(enc_r(cpu_pkg::op_sw, 5'd1, 5'd2, 5'd3, 2'd0));
		issue(enc_i(cpu_pkg::op_mtsr, 5'd1, 5'd0, 15'd2));

		for (int i = 0; i < 18; i++) begin
			set_reg(5'd1, rand_word());
			w = rand_word();
			issue(enc_u(cpu_pkg::op_movi, 5'd2, w[19:0]));
			issue(enc_r(rr_ops[i % 6], rand_reg(), 5'd1, 5'd2, 2'd0));
		end

		// immediates with sign bits clear, then set.
		for (int s = 0; s < 2; s++) begin
			w = rand_word();
			w[14] = s[0];
			w[19] = s[0];
			set_reg(5'd1, rand_word());
			issue(enc_i(cpu_pkg::op_addi, rand_reg(), 5'd1, w[14:0]));
			issue(enc_i(cpu_pkg::op_ori, rand_reg(), 5'd1, w[14:0]));
			issue(enc_i(cpu_pkg::op_slli, rand_reg(), 5'd1, w[14:0]));
			issue(enc_u(cpu_pkg::op_movi, rand_reg(), w[19:0]));
			issue(enc_u(cpu_pkg::op_sethi, rand_reg(), w[19:0]));
		end

		// fill the whole memory first.
		set_reg(5'd1, 32'd0);
		for (int k = 0; k < 256; k++) begin
			set_reg(5'd2, {k[7:0], ~k[7:0], k[7:0] ^ 8'ha5, 8'h3c});
			issue(enc_i(cpu_pkg::op_swi, 5'd2, 5'd1, k[14:0]));
		end
		for (int s = 0; s < 4; s++) begin
			set_reg(5'd3, rand_word());
			set_reg(5'd4, rand_word());
			set_reg(5'd5, rand_word());
			w = rand_word();
			issue(enc_r(cpu_pkg::op_sw, 5'd5, 5'd3, 5'd4, s[1:0]));
			issue(enc_r(cpu_pkg::op_lw, 5'd6, 5'd3, 5'd4, s[1:0]));
			issue(enc_i(cpu_pkg::op_swi, 5'd4, 5'd3, w[14:0]));
			issue(enc_i(cpu_pkg::op_lwi, 5'd7, 5'd3, w[14:0]));
			issue(enc_r(cpu_pkg::op_lwr, 5'd8, 5'd3, 5'd0, 2'd0));
		end

		repeat (4) issue(enc_r(cpu_pkg::op_lnk, 5'd0, 5'd0, 5'd0, 2'd0));
		for (int s = 0; s < 4; s++) begin
			set_reg(5'd5, rand_word());
			issue(enc_i(cpu_pkg::op_mtsr, 5'd5, 5'd0, s[14:0]));
			issue(enc_i(cpu_pkg::op_mfsr, rand_reg(), 5'd0, s[14:0]));
		end

		// dependent chain on r0 to r7 at minimum spacing.
		for (int i = 0; i < 40; i++) begin
			w = rand_word();
			u = rand_word();
			w[25:24] = 2'b00;
			w[20:19] = 2'b00;
			w[15] = 1'b0;
			issue({all_ops[u[7:0] % 8'd21], w[25:0]});
		end

		n = 0;
		while (exp_addr.size() != 0 && n < 20) begin
			@(negedge clk);
			n++;
		end
		repeat (4) @(negedge clk);
		if (exp_addr.size() == 0) begin
			$display("Testbench passed");
			$finish;
		end else begin
			$display("expected register writes never appeared on the trace");
			stop_run();
		end
	end

endmodule

// ==== tb/exec_core_chk.sv ====
`timescale 1ns/1ps
module exec_core_chk (
	input logic        clk,
	input logic        rst,
	input logic        instr_valid,
	input logic [31:0] instr,
	input logic        wb_valid,
	input logic [4:0]  wb_addr,
	input logic [31:0] wb_data
);

	function automatic logic writes_reg(input logic [5:0] op);
		case (cpu_pkg::opcode_e'(op))
			cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_and, cpu_pkg::op_or,
			cpu_pkg::op_xor, cpu_pkg::op_sll, cpu_pkg::op_addi, cpu_pkg::op_ori,
			cpu_pkg::op_slli, cpu_pkg::op_movi, cpu_pkg::op_sethi, cpu_pkg::op_lwi,
			cpu_pkg::op_lw, cpu_pkg::op_lwr, cpu_pkg::op_lnk, cpu_pkg::op_mov,
			cpu_pkg::op_mfsr: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	issue_spacing: assert property (@(posedge clk) disable iff (rst)
		instr_valid |=> !instr_valid)
		else $error("instr_valid high on two consecutive cycles");

	quiet_after_reset: assert property (@(posedge clk) rst |=> !wb_valid)
		else $error("wb_valid high in the cycle after reset");

	trace_known: assert property (@(posedge clk) disable iff (rst)
		wb_valid |-> !$isunknown({wb_addr, wb_data}))
		else $error("unknown bits on the trace port");

	// fixed two-cycle latency to the trace.
	trace_latency: assert property (@(posedge clk) disable iff (rst)
		instr_valid && writes_reg(instr[31:26]) |-> ##2 wb_valid)
		else $error("missing trace write two cycles after issue");

endmodule

// ==== verilog/exec_core.sv ====
`timescale 1ns/1ps
module exec_core (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       instr_valid,
	input  logic [31:0]                instr,
	input  logic [cpu_pkg::xlen-1:0]   instr_pc,
	output logic                       wb_valid,
	output logic [cpu_pkg::reg_aw-1:0] wb_addr,
	output logic [cpu_pkg::xlen-1:0]   wb_data
);

	localparam int w = cpu_pkg::xlen;

	cpu_pkg::alu_src2_e dec_sel_src2;
	cpu_pkg::imm_ext_e dec_sel_imm;
	cpu_pkg::mem_addr_e dec_sel_maddr, ex_sel_maddr, x3_sel_maddr;
	cpu_pkg::wr_addr_e dec_sel_wraddr, ex_sel_wraddr;
	cpu_pkg::wr_src_e dec_sel_wrreg, ex_sel_wrreg, x3_sel_wrreg;
	cpu_pkg::alu_op_e dec_alu_op, ex_alu_op;
	logic dec_reg_we, dec_mem_we, dec_sr_we;
	logic [w-1:0] ra_data, rb_data, rt_data, alu_src2, imm_extend;

	logic ex_valid, ex_reg_we, ex_mem_we, ex_sr_we;
	logic [w-1:0] ex_ra_data, ex_src2, ex_imm, ex_rt_data, ex_pc4, alu_result;
	logic [cpu_pkg::reg_aw-1:0] ex_rt_addr, ex_wr_addr;

	logic x3_valid, x3_reg_we, x3_mem_we, x3_sr_we;
	logic [w-1:0] x3_alu_result, x3_imm, x3_rt_data, x3_ra_data, x3_pc4;
	logic [cpu_pkg::reg_aw-1:0] x3_wr_addr;
	logic [w-1:0] mem_address, mem_rdata, sr_rdata, write_reg_data;

	decoder decoder_i (
		.opcode(instr[cpu_pkg::op_hi:cpu_pkg::op_lo]),
		.select_alu_src2(dec_sel_src2), .select_imm_extend(dec_sel_imm),
		.select_mem_addr(dec_sel_maddr), .select_write_reg_addr(dec_sel_wraddr),
		.select_write_reg(dec_sel_wrreg), .alu_op(dec_alu_op),
		.reg_we(dec_reg_we), .mem_we(dec_mem_we), .sr_we(dec_sr_we)
	);

	reg_file reg_file_i (
		.clk(clk), .rst(rst),
		.ra_addr(instr[cpu_pkg::ra_hi:cpu_pkg::ra_lo]),
		.rb_addr(instr[cpu_pkg::rb_hi:cpu_pkg::rb_lo]),
		.rt_addr(instr[cpu_pkg::rt_hi:cpu_pkg::rt_lo]),
		.ra_data(ra_data), .rb_data(rb_data), .rt_data(rt_data),
		.we(x3_valid & x3_reg_we), .wr_addr(x3_wr_addr), .wr_data(write_reg_data)
	);

	muxs muxs_i (
		.sub_op_sv(instr[cpu_pkg::sv_hi:cpu_pkg::sv_lo]),
		.reg_rb_data(rb_data), .reg_rt_data(rt_data), .reg_rt_addr(ex_rt_addr),
		.xreg3_alu_result(x3_alu_result), .xreg3_imm_extend(x3_imm),
		.mem_read_data(mem_rdata), .xreg3_write_reg_pc(x3_pc4),
		.xreg3_reg_rt_data(x3_rt_data), .xreg3_system_reg(sr_rdata),
		.xreg3_reg_ra_data(x3_ra_data),
		.imm_5bit(instr[cpu_pkg::imm5_hi:cpu_pkg::imm5_lo]),
		.imm_15bit(instr[cpu_pkg::imm15_hi:cpu_pkg::imm15_lo]),
		.imm_20bit(instr[cpu_pkg::imm20_hi:cpu_pkg::imm20_lo]),
		.select_alu_src2(dec_sel_src2), .select_imm_extend(dec_sel_imm),
		.select_mem_addr(x3_sel_maddr), .select_write_reg_addr(ex_sel_wraddr),
		.select_write_reg(x3_sel_wrreg),
		.alu_src2(alu_src2), .imm_extend(imm_extend), .mem_address(mem_address),
		.write_reg_addr(ex_wr_addr), .write_reg_data(write_reg_data)
	);

	alu alu_i (.op(ex_alu_op), .a(ex_ra_data), .b(ex_src2), .result(alu_result));

	data_mem data_mem_i (
		.clk(clk), .addr(mem_address[cpu_pkg::mem_aw+1:2]), .rdata(mem_rdata),
		.we(x3_mem_we), .wdata(x3_rt_data)
	);

	sys_reg sys_reg_i (
		.clk(clk), .rst(rst), .addr(x3_imm[cpu_pkg::sr_hi:cpu_pkg::sr_lo]),
		.rdata(sr_rdata), .we(x3_sr_we), .wdata(x3_rt_data)
	);

	// valid bits and write enables, gated per stage.
	always_ff @(posedge clk) begin
		if (rst) begin
			ex_valid <= 1'b0;
			ex_reg_we <= 1'b0;
			ex_mem_we <= 1'b0;
			ex_sr_we <= 1'b0;
			x3_valid <= 1'b0;
			x3_reg_we <= 1'b0;
			x3_mem_we <= 1'b0;
			x3_sr_we <= 1'b0;
		end else begin
			ex_valid <= instr_valid;
			ex_reg_we <= instr_valid & dec_reg_we;
			ex_mem_we <= instr_valid & dec_mem_we;
			ex_sr_we <= instr_valid & dec_sr_we;
			x3_valid <= ex_valid;
			x3_reg_we <= ex_valid & ex_reg_we;
			x3_mem_we <= ex_valid & ex_mem_we;
			x3_sr_we <= ex_valid & ex_sr_we;
		end
	end

	always_ff @(posedge clk) begin
		ex_alu_op <= dec_alu_op;
		ex_sel_maddr <= dec_sel_maddr;
		ex_sel_wraddr <= dec_sel_wraddr;
		ex_sel_wrreg <= dec_sel_wrreg;
		ex_ra_data <= ra_data;
		ex_src2 <= alu_src2;
		ex_imm <= imm_extend;
		ex_rt_data <= rt_data;
		ex_pc4 <= instr_pc + 32'd4;
		ex_rt_addr <= instr[cpu_pkg::rt_hi:cpu_pkg::rt_lo];
		x3_sel_maddr <= ex_sel_maddr;
		x3_sel_wrreg <= ex_sel_wrreg;
		x3_alu_result <= alu_result;
		x3_imm <= ex_imm;
		x3_rt_data <= ex_rt_data;
		x3_ra_data <= ex_ra_data;
		x3_pc4 <= ex_pc4;
		x3_wr_addr <= ex_wr_addr;
	end

	// trace mirrors the register file write port.
	assign wb_valid = x3_valid & x3_reg_we;
	assign wb_addr = x3_wr_addr;
	assign wb_data = write_reg_data;

endmodule

// ==== verilog/sys_reg.sv ====
`timescale 1ns/1ps
module sys_reg (
	input  logic                      clk,
	input  logic                      rst,
	input  logic [cpu_pkg::sr_aw-1:0] addr,
	output logic [cpu_pkg::xlen-1:0]  rdata,
	input  logic                      we,
	input  logic [cpu_pkg::xlen-1:0]  wdata
);

	logic [cpu_pkg::xlen-1:0] sr [0:(1<<cpu_pkg::sr_aw)-1];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < (1 << cpu_pkg::sr_aw); i++) begin
				sr[i] <= '0;
			end
		end else if (we) begin
			sr[addr] <= wdata;
		end
	end

	assign rdata = we ? wdata : sr[addr];

endmodule

// ==== verilog/data_mem.sv ====
`timescale 1ns/1ps
module data_mem (
	input  logic                       clk,
	input  logic [cpu_pkg::mem_aw-1:0] addr,
	output logic [cpu_pkg::xlen-1:0]   rdata,
	input  logic                       we,
	input  logic [cpu_pkg::xlen-1:0]   wdata
);

	logic [cpu_pkg::xlen-1:0] mem [0:(1<<cpu_pkg::mem_aw)-1];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;
		end
	end

	// single address, so a write always hits the read.
	assign rdata = we ? wdata : mem[addr];

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/1ps
module alu (
	input  cpu_pkg::alu_op_e         op,
	input  logic [cpu_pkg::xlen-1:0] a,
	input  logic [cpu_pkg::xlen-1:0] b,
	output logic [cpu_pkg::xlen-1:0] result
);

	logic [4:0] shamt;

	// shift amount from the low bits of b.
	assign shamt = b[4:0];

	always_comb begin
		case (op)
			cpu_pkg::alu_add: result = a + b;
			cpu_pkg::alu_sub: result = a - b;
			cpu_pkg::alu_and: result = a & b;
			cpu_pkg::alu_or: result = a | b;
			cpu_pkg::alu_xor: result = a ^ b;
			cpu_pkg::alu_sll: result = a << shamt;
			default: result = '0;
		endcase
	end

endmodule

// ==== verilog/muxs.sv ====
`timescale 1ns/1ps
module muxs (
	input  logic [1:0]                 sub_op_sv,
	input  logic [cpu_pkg::xlen-1:0]   reg_rb_data,
	input  logic [cpu_pkg::xlen-1:0]   reg_rt_data,
	input  logic [cpu_pkg::reg_aw-1:0] reg_rt_addr,
	input  logic [cpu_pkg::xlen-1:0]   xreg3_alu_result,
	input  logic [cpu_pkg::xlen-1:0]   xreg3_imm_extend,
	input  logic [cpu_pkg::xlen-1:0]   mem_read_data,
	input  logic [cpu_pkg::xlen-1:0]   xreg3_write_reg_pc,
	input  logic [cpu_pkg::xlen-1:0]   xreg3_reg_rt_data,
	input  logic [cpu_pkg::xlen-1:0]   xreg3_system_reg,
	input  logic [cpu_pkg::xlen-1:0]   xreg3_reg_ra_data,
	input  logic [4:0]                 imm_5bit,
	input  logic [14:0]                imm_15bit,
	input  logic [19:0]                imm_20bit,
	input  cpu_pkg::alu_src2_e         select_alu_src2,
	input  cpu_pkg::imm_ext_e          select_imm_extend,
	input  cpu_pkg::mem_addr_e         select_mem_addr,
	input  cpu_pkg::wr_addr_e          select_write_reg_addr,
	input  cpu_pkg::wr_src_e           select_write_reg,
	output logic [cpu_pkg::xlen-1:0]   alu_src2,
	output logic [cpu_pkg::xlen-1:0]   imm_extend,
	output logic [cpu_pkg::xlen-1:0]   mem_address,
	output logic [cpu_pkg::reg_aw-1:0] write_reg_addr,
	output logic [cpu_pkg::xlen-1:0]   write_reg_data
);

	localparam int w = cpu_pkg::xlen;

	always_comb begin
		case (select_imm_extend)
			cpu_pkg::imm_5_ze: imm_extend = {{(w-5){1'b0}}, imm_5bit};
			cpu_pkg::imm_15_se: imm_extend = {{(w-15){imm_15bit[14]}}, imm_15bit};
			cpu_pkg::imm_15_ze: imm_extend = {{(w-15){1'b0}}, imm_15bit};
			cpu_pkg::imm_20_se: imm_extend = {{(w-20){imm_20bit[19]}}, imm_20bit};
			cpu_pkg::imm_20_hi: imm_extend = {imm_20bit, {(w-20){1'b0}}};
			default: imm_extend = '0;
		endcase
	end

	always_comb begin
		case (select_alu_src2)
			cpu_pkg::src2_rb: alu_src2 = reg_rb_data;
			cpu_pkg::src2_imm: alu_src2 = imm_extend;
			// word offset, imm15 in words.
			cpu_pkg::src2_lswi: alu_src2 = {{(w-17){imm_15bit[14]}}, imm_15bit, 2'b00};
			cpu_pkg::src2_lsw: alu_src2 = reg_rb_data << sub_op_sv;
			default: alu_src2 = reg_rt_data;
		endcase
	end

	always_comb begin
		case (select_write_reg_addr)
			cpu_pkg::wraddr_lp: write_reg_addr = cpu_pkg::lp_reg;
			default: write_reg_addr = reg_rt_addr;
		endcase
	end

	// xreg3 side.
	always_comb begin
		case (select_mem_addr)
			cpu_pkg::maddr_ra: mem_address = xreg3_reg_ra_data;
			default: mem_address = xreg3_alu_result;
		endcase
	end

	always_comb begin
		case (select_write_reg)
			cpu_pkg::wrreg_alu: write_reg_data = xreg3_alu_result;
			cpu_pkg::wrreg_imm: write_reg_data = xreg3_imm_extend;
			cpu_pkg::wrreg_mem: write_reg_data = mem_read_data;
			cpu_pkg::wrreg_pc: write_reg_data = xreg3_write_reg_pc;
			cpu_pkg::wrreg_rt: write_reg_data = xreg3_reg_rt_data;
			cpu_pkg::wrreg_sr: write_reg_data = xreg3_system_reg;
			default: write_reg_data = '0;
		endcase
	end

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ps
module reg_file (
	input  logic                       clk,
	input  logic                       rst,
	input  logic [cpu_pkg::reg_aw-1:0] ra_addr,
	input  logic [cpu_pkg::reg_aw-1:0] rb_addr,
	input  logic [cpu_pkg::reg_aw-1:0] rt_addr,
	output logic [cpu_pkg::xlen-1:0]   ra_data,
	output logic [cpu_pkg::xlen-1:0]   rb_data,
	output logic [cpu_pkg::xlen-1:0]   rt_data,
	input  logic                       we,
	input  logic [cpu_pkg::reg_aw-1:0] wr_addr,
	input  logic [cpu_pkg::xlen-1:0]   wr_data
);

	logic [cpu_pkg::xlen-1:0] regs [0:(1<<cpu_pkg::reg_aw)-1];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < (1 << cpu_pkg::reg_aw); i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// write-through on all three read ports.
	assign ra_data = (we && wr_addr == ra_addr) ? wr_data : regs[ra_addr];
	assign rb_data = (we && wr_addr == rb_addr) ? wr_data : regs[rb_addr];
	assign rt_data = (we && wr_addr == rt_addr) ? wr_data : regs[rt_addr];

endmodule

// ==== verilog/decoder.sv ====
`timescale 1ns/1ps
module decoder (
	input  logic [cpu_pkg::op_w-1:0] opcode,
	output cpu_pkg::alu_src2_e       select_alu_src2,
	output cpu_pkg::imm_ext_e        select_imm_extend,
	output cpu_pkg::mem_addr_e       select_mem_addr,
	output cpu_pkg::wr_addr_e        select_write_reg_addr,
	output cpu_pkg::wr_src_e         select_write_reg,
	output cpu_pkg::alu_op_e         alu_op,
	output logic                     reg_we,
	output logic                     mem_we,
	output logic                     sr_we
);

	always_comb begin
		select_alu_src2 = cpu_pkg::src2_rb;
		select_imm_extend = cpu_pkg::imm_15_se;
		select_mem_addr = cpu_pkg::maddr_alu;
		select_write_reg_addr = cpu_pkg::wraddr_rt;
		select_write_reg = cpu_pkg::wrreg_alu;
		alu_op = cpu_pkg::alu_add;
		reg_we = 1'b0;
		mem_we = 1'b0;
		sr_we = 1'b0;
		case (cpu_pkg::opcode_e'(opcode))
			cpu_pkg::op_add: reg_we = 1'b1;
			cpu_pkg::op_sub: begin
				alu_op = cpu_pkg::alu_sub;
				reg_we = 1'b1;
			end
			cpu_pkg::op_and: begin
				alu_op = cpu_pkg::alu_and;
				reg_we = 1'b1;
			end
			cpu_pkg::op_or: begin
				alu_op = cpu_pkg::alu_or;
				reg_we = 1'b1;
			end
			cpu_pkg::op_xor: begin
				alu_op = cpu_pkg::alu_xor;
				reg_we = 1'b1;
			end
			cpu_pkg::op_sll: begin
				alu_op = cpu_pkg::alu_sll;
				reg_we = 1'b1;
			end
			cpu_pkg::op_addi: begin
				select_alu_src2 = cpu_pkg::src2_imm;
				reg_we = 1'b1;
			end
			cpu_pkg::op_ori: begin
				select_alu_src2 = cpu_pkg::src2_imm;
				select_imm_extend = cpu_pkg::imm_15_ze;
				alu_op = cpu_pkg::alu_or;
				reg_we = 1'b1;
			end
			cpu_pkg::op_slli: begin
				select_alu_src2 = cpu_pkg::src2_imm;
				select_imm_extend = cpu_pkg::imm_5_ze;
				alu_op = cpu_pkg::alu_sll;
				reg_we = 1'b1;
			end
			cpu_pkg::op_movi: begin
				select_imm_extend = cpu_pkg::imm_20_se;
				select_write_reg = cpu_pkg::wrreg_imm;
				reg_we = 1'b1;
			end
			cpu_pkg::op_sethi: begin
				select_imm_extend = cpu_pkg::imm_20_hi;
				select_write_reg = cpu_pkg::wrreg_imm;
				reg_we = 1'b1;
			end
			cpu_pkg::op_lwi, cpu_pkg::op_swi: begin
				select_alu_src2 = cpu_pkg::src2_lswi;
				select_write_reg = cpu_pkg::wrreg_mem;
				reg_we = (opcode == cpu_pkg::op_lwi);
				mem_we = (opcode == cpu_pkg::op_swi);
			end
			cpu_pkg::op_lw, cpu_pkg::op_sw: begin
				select_alu_src2 = cpu_pkg::src2_lsw;
				select_write_reg = cpu_pkg::wrreg_mem;
				reg_we = (opcode == cpu_pkg::op_lw);
				mem_we = (opcode == cpu_pkg::op_sw);
			end
			cpu_pkg::op_lwr: begin
				select_mem_addr = cpu_pkg::maddr_ra;
				select_write_reg = cpu_pkg::wrreg_mem;
				reg_we = 1'b1;
			end
			cpu_pkg::op_lnk: begin
				select_write_reg_addr = cpu_pkg::wraddr_lp;
				select_write_reg = cpu_pkg::wrreg_pc;
				reg_we = 1'b1;
			end
			cpu_pkg::op_mov: begin
				select_write_reg = cpu_pkg::wrreg_rt;
				reg_we = 1'b1;
			end
			// sr number rides along in the zero-extended imm15.
			cpu_pkg::op_mtsr: begin
				select_imm_extend = cpu_pkg::imm_15_ze;
				sr_we = 1'b1;
			end
			cpu_pkg::op_mfsr: begin
				select_imm_extend = cpu_pkg::imm_15_ze;
				select_write_reg = cpu_pkg::wrreg_sr;
				reg_we = 1'b1;
			end
			default: begin
			end
		endcase
	end

endmodule

// ==== verilog/cpu_pkg.sv ====
package cpu_pkg;

	localparam int xlen = 32;
	localparam int reg_aw = 5;
	localparam int mem_aw = 8;
	localparam int sr_aw = 2;
	localparam int op_w = 6;
	localparam logic [reg_aw-1:0] lp_reg = 5'd30;

	// instruction field positions.
	localparam int op_hi = 31;
	localparam int op_lo = 26;
	localparam int rt_hi = 25;
	localparam int rt_lo = 21;
	localparam int ra_hi = 20;
	localparam int ra_lo = 16;
	localparam int rb_hi = 15;
	localparam int rb_lo = 11;
	localparam int sv_hi = 9;
	localparam int sv_lo = 8;
	localparam int imm5_hi = 14;
	localparam int imm5_lo = 10;
	localparam int imm15_hi = 14;
	localparam int imm15_lo = 0;
	localparam int imm20_hi = 19;
	localparam int imm20_lo = 0;
	// system register number, low bits of imm15.
	localparam int sr_hi = sr_aw - 1;
	localparam int sr_lo = 0;

	typedef enum logic [op_w-1:0] {
		op_add   = 6'h00,
		op_sub   = 6'h01,
		op_and   = 6'h02,
		op_or    = 6'h03,
		op_xor   = 6'h04,
		op_sll   = 6'h05,
		op_addi  = 6'h08,
		op_ori   = 6'h09,
		op_slli  = 6'h0a,
		op_movi  = 6'h0b,
		op_sethi = 6'h0c,
		op_lwi   = 6'h10,
		op_swi   = 6'h11,
		op_lw    = 6'h12,
		op_sw    = 6'h13,
		op_lwr   = 6'h14,
		op_lnk   = 6'h18,
		op_mov   = 6'h19,
		op_mtsr  = 6'h1c,
		op_mfsr  = 6'h1d,
		op_nop   = 6'h3f
	} opcode_e;

	typedef enum logic [1:0] {
		src2_rb, src2_imm, src2_lswi, src2_lsw
	} alu_src2_e;

	typedef enum logic [2:0] {
		imm_5_ze, imm_15_se, imm_15_ze, imm_20_se, imm_20_hi
	} imm_ext_e;

	typedef enum logic [0:0] {
		maddr_alu, maddr_ra
	} mem_addr_e;

	typedef enum logic [0:0] {
		wraddr_rt, wraddr_lp
	} wr_addr_e;

	typedef enum logic [2:0] {
		wrreg_alu, wrreg_imm, wrreg_mem, wrreg_pc, wrreg_rt, wrreg_sr
	} wr_src_e;

	typedef enum logic [2:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_sll
	} alu_op_e;

endpackage
